/* Makefile */
# Verilator build and run for the RV32I subset core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SOURCES := $(wildcard source/*.sv dv/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is not trusted, the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/core_props.sv */
/* Concurrent checks on reset, the scoreboard stall and the cache address.
   Bound to every instance of the core from the testbench. */

`include "core_config.svh"

module core_props (
  input logic                  clock,
  input logic                  reset,
  input logic                  icache_data_valid,
  input logic [`CORE_XLEN-1:0] icache_addr,
  input core_pkg::retire_t     retire,
  input logic                  hazard,
  input logic                  redirect
);

  // once reset has been seen for a cycle nothing may retire
  assert property (@(posedge clock) reset && $past(reset) |-> !retire.valid)
    else $error("retire.valid high while reset is held");

  // a stall lasts one cycle and ends as the producer retires
  assert property (@(posedge clock) disable iff (reset)
    hazard |=> retire.valid && !hazard)
    else $error("hazard did not resolve through a retire in the next cycle");

  // the address moves only with a strobe or a redirect
  assert property (@(posedge clock) disable iff (reset)
    !icache_data_valid |=> redirect || $stable(icache_addr))
    else $error("icache_addr changed while waiting for the cache");

endmodule

/* dv/core_tb.sv */
/* Directed testbench for the core. A cache model serves each test program with
   LFSR latency and a reference model predicts the retire stream. */

`include "core_config.svh"

module core_tb;

  import core_pkg::*;

  localparam int CLOCK_PERIOD     = 8;
  localparam int RESET_CYCLES     = 10;
  localparam int DRIVE_DELAY      = 1;
  localparam int DRAIN_CYCLES     = 24;
  localparam int MAX_LATENCY_BITS = 2;
  // worst fetch wait plus a re-served word after a stall and dropped strobes after a redirect
  localparam int CYCLES_PER_WORD  = 4 * (1 << MAX_LATENCY_BITS) + 4;
  localparam logic [31:0] LFSR_SEED = 32'd67873;

  logic                       clock;
  logic                       reset;
  logic [`CORE_INST_BITS-1:0] icache_data;
  logic                       icache_data_valid;
  logic [`CORE_XLEN-1:0]      icache_addr;
  retire_t                    retire;

  logic [31:0]           program_words [$];
  retire_t               expected [$];
  logic [31:0]           lfsr;
  int                    latency_bits;
  int                    mismatch_count;
  int                    failure_count;
  int                    cycle_count;
  int                    cycle_budget;
  logic                  reset_seen;
  logic [`CORE_XLEN-1:0] served_addr;
  int                    wait_cycles;

  core i_core (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .icache_addr       (icache_addr),
    .retire            (retire)
  );

  bind core core_props i_props (
    .clock             (clock),
    .reset             (reset),
    .icache_data_valid (icache_data_valid),
    .icache_addr       (icache_addr),
    .retire            (retire),
    .hazard            (hazard),
    .redirect          (redirect)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    logic [31:0] index;
    logic [31:0] word;
    index = addr >> 2;
    if (addr[1:0] == 2'b00 && index < program_words.size()) begin
      word = program_words[index];
    end else begin
      // filler carries opcode zero, which the core drops
      word = (addr * 32'h9e3779b1) & 32'hffffff80;
    end
    return word;
  endfunction

  // cache model starts a new request on a new address or after a finished transfer
  always @(posedge clock) begin
    reset_seen = reset;
    #DRIVE_DELAY;
    if (reset_seen) begin
      icache_data_valid = 1'b0;
      wait_cycles       = -1;
    end else begin
      if (wait_cycles < 0 || icache_data_valid || icache_addr != served_addr) begin
        served_addr = icache_addr;
        wait_cycles = random_bits(latency_bits);
      end
      if (wait_cycles == 0) begin
        icache_data_valid = 1'b1;
        icache_data       = memory_word(served_addr);
      end else begin
        icache_data_valid = 1'b0;
        wait_cycles--;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_budget) begin
      $display("Error: run stopped after %0d cycles with the tests unfinished", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] r_type(input int funct7, input int funct3, input int rd,
                                         input int rs1, input int rs2);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  // funct3 0 is BEQ, 1 is BNE
  function automatic logic [31:0] branch_word(input int funct3, input int rs1, input int rs2,
                                              input int offset);
    return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0], offset[4:1],
            offset[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input int rd, input int offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got.pc !== exp.pc) begin
      $display("Mismatch at %0t: retire.pc got %h expected %h", $time, got.pc, exp.pc);
      mismatch_count++;
    end
    if (got.rd_valid !== exp.rd_valid) begin
      $display("Mismatch at %0t: retire.rd_valid got %b expected %b (pc %h)",
               $time, got.rd_valid, exp.rd_valid, exp.pc);
      mismatch_count++;
    end else if (exp.rd_valid) begin
      if (got.rd !== exp.rd) begin
        $display("Mismatch at %0t: retire.rd got %0d expected %0d (pc %h)",
                 $time, got.rd, exp.rd, exp.pc);
        mismatch_count++;
      end
      if (got.rd_data !== exp.rd_data) begin
        $display("Mismatch at %0t: retire.rd_data got %h expected %h (pc %h)",
                 $time, got.rd_data, exp.rd_data, exp.pc);
        mismatch_count++;
      end
    end
  endtask

  task automatic check_addr(input logic [`CORE_XLEN-1:0] got, input logic [`CORE_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: icache_addr got %h expected %h", $time, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // architectural model of the subset, walks the program in order
  task automatic build_expected();
    logic [31:0] arch_regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] word;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] imm;
    retire_t     item;
    int          steps;
    expected.delete();
    for (int i = 0; i < 32; i++) begin
      arch_regs[i] = '0;
    end
    pc    = `CORE_RESET_PC;
    steps = 0;
    while ((pc >> 2) < program_words.size() && steps < 256) begin
      word       = program_words[pc >> 2];
      src_a      = arch_regs[word[19:15]];
      src_b      = arch_regs[word[24:20]];
      next_pc    = pc + 32'd4;
      item       = '0;
      item.valid = 1'b1;
      item.pc    = pc;
      item.rd    = word[11:7];
      case (word[6:0])
        7'b0110011: begin
          item.rd_valid = 1'b1;
          case (word[14:12])
            3'd0: item.rd_data = word[30] ? src_a - src_b : src_a + src_b;
            3'd7: item.rd_data = src_a & src_b;
            3'd6: item.rd_data = src_a | src_b;
            3'd4: item.rd_data = src_a ^ src_b;
            default: item.rd_data = {31'b0, $signed(src_a) < $signed(src_b)};
          endcase
        end
        7'b0010011: begin
          imm           = {{20{word[31]}}, word[31:20]};
          item.rd_valid = 1'b1;
          item.rd_data  = src_a + imm;
        end
        7'b0110111: begin
          item.rd_valid = 1'b1;
          item.rd_data  = {word[31:12], 12'b0};
        end
        7'b1100011: begin
          imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
          // funct3 bit 0 inverts the equality test
          if ((src_a == src_b) != word[12]) begin
            next_pc = pc + imm;
          end
        end
        7'b1101111: begin
          imm           = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
          item.rd_valid = 1'b1;
          item.rd_data  = pc + 32'd4;
          next_pc       = pc + imm;
        end
        default: item.valid = 1'b0;
      endcase
      // x0 stays zero and retires without a write
      if (item.rd == '0) begin
        item.rd_valid = 1'b0;
      end
      if (item.rd_valid) begin
        arch_regs[item.rd] = item.rd_data;
      end
      if (item.valid) begin
        expected.push_back(item);
      end
      pc = next_pc;
      steps++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clock);
    @(negedge clock);
    check_level("retire.valid", retire.valid, 1'b0);
    check_addr(icache_addr, `CORE_RESET_PC);
    @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clock);
    check_addr(icache_addr, `CORE_RESET_PC);
  endtask

  task automatic run_program(input string name);
    retire_t exp_item;
    int      retired;
    build_expected();
    cycle_budget += 2 * RESET_CYCLES + DRAIN_CYCLES
                    + CYCLES_PER_WORD * (program_words.size() + 1);
    apply_reset();
    retired = 0;
    while (expected.size() > 0) begin
      @(negedge clock);
      if (retire.valid) begin
        exp_item = expected.pop_front();
        check_retire(retire, exp_item);
        retired++;
      end
    end
    repeat (DRAIN_CYCLES) begin
      @(negedge clock);
      if (retire.valid) begin
        $display("Error at %0t: %s retired an extra instruction at pc %h",
                 $time, name, retire.pc);
        failure_count++;
      end
    end
    $display("%s: %0d instructions retired", name, retired);
  endtask

  task automatic load_alu_program();
    program_words.delete();
    program_words.push_back(addi_word(1, 0, 5));
    program_words.push_back(addi_word(2, 0, -3));
    program_words.push_back(lui_word(3, 'h12345));
    program_words.push_back(addi_word(4, 0, 'h7ff));
    program_words.push_back(addi_word(5, 0, -2048));
    program_words.push_back(lui_word(6, 'hfffff));
    program_words.push_back(r_type(0, 0, 7, 1, 2));
    program_words.push_back(r_type(32, 0, 8, 3, 4));
    program_words.push_back(r_type(0, 7, 9, 2, 4));
    program_words.push_back(r_type(0, 6, 10, 5, 1));
    program_words.push_back(r_type(0, 4, 11, 6, 3));
    // signed compare both ways
    program_words.push_back(r_type(0, 2, 12, 2, 1));
    program_words.push_back(r_type(0, 2, 13, 1, 2));
  endtask

  task automatic load_dependent_program();
    program_words.delete();
    program_words.push_back(addi_word(1, 0, 1));
    program_words.push_back(addi_word(1, 1, 2));
    program_words.push_back(r_type(0, 0, 2, 1, 1));
    program_words.push_back(r_type(32, 0, 3, 2, 1));
    program_words.push_back(r_type(0, 4, 4, 3, 2));
    program_words.push_back(r_type(0, 2, 5, 3, 4));
    program_words.push_back(r_type(0, 0, 6, 5, 5));
    program_words.push_back(r_type(0, 6, 7, 6, 4));
    program_words.push_back(addi_word(8, 7, -10));
    program_words.push_back(r_type(0, 7, 9, 8, 7));
  endtask

  task automatic load_branch_program();
    program_words.delete();
    program_words.push_back(addi_word(1, 0, 7));
    program_words.push_back(addi_word(2, 0, 7));
    program_words.push_back(branch_word(0, 1, 2, 12));
    program_words.push_back(addi_word(3, 0, 1));
    program_words.push_back(addi_word(3, 0, 2));
    program_words.push_back(branch_word(1, 1, 2, 8));
    program_words.push_back(addi_word(4, 0, 3));
    program_words.push_back(branch_word(1, 1, 4, 12));
    program_words.push_back(addi_word(5, 0, 1));
    program_words.push_back(addi_word(5, 0, 2));
    program_words.push_back(jal_word(6, 12));
    program_words.push_back(addi_word(7, 0, 1));
    program_words.push_back(addi_word(7, 0, 2));
    program_words.push_back(r_type(0, 0, 8, 6, 1));
    // leaves the program through a link-less jump
    program_words.push_back(jal_word(0, 8));
    program_words.push_back(addi_word(9, 0, 9));
  endtask

  task automatic load_x0_program();
    program_words.delete();
    program_words.push_back(addi_word(0, 0, 5));
    program_words.push_back(lui_word(0, 'habcde));
    program_words.push_back(r_type(0, 0, 0, 0, 0));
    program_words.push_back(addi_word(1, 0, 4));
    program_words.push_back(r_type(0, 0, 0, 1, 1));
    program_words.push_back(r_type(0, 0, 2, 0, 1));
    program_words.push_back(r_type(0, 6, 3, 0, 0));
    program_words.push_back(r_type(32, 0, 5, 0, 1));
  endtask

  task automatic test_reset_idle();
    program_words.delete();
    latency_bits = 0;
    run_program("reset_idle");
  endtask

  task automatic test_independent_alu();
    latency_bits = 0;
    load_alu_program();
    run_program("independent_alu");
  endtask

  task automatic test_dependent_chain();
    latency_bits = 0;
    load_dependent_program();
    run_program("dependent_chain");
  endtask

  task automatic test_branches();
    latency_bits = 0;
    load_branch_program();
    run_program("branches");
  endtask

  task automatic test_x0_writes();
    latency_bits = 0;
    load_x0_program();
    run_program("x0_writes");
  endtask

  task automatic test_random_latency();
    latency_bits = MAX_LATENCY_BITS;
    load_alu_program();
    run_program("alu_random_latency");
    load_dependent_program();
    run_program("dependent_random_latency");
    load_branch_program();
    run_program("branches_random_latency");
    load_x0_program();
    run_program("x0_random_latency");
  endtask

  initial begin
    reset             = 1'b1;
    icache_data       = '0;
    icache_data_valid = 1'b0;
    lfsr              = LFSR_SEED;
    latency_bits      = 0;
    wait_cycles       = -1;
    served_addr       = '0;
    mismatch_count    = 0;
    failure_count     = 0;
    cycle_count       = 0;
    cycle_budget      = 0;
    test_reset_idle();
    test_independent_alu();
    test_dependent_chain();
    test_branches();
    test_x0_writes();
    test_random_latency();
    $display("closing: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* include/core_config.svh */
/* Configuration macros for the RV32I subset core.
   Included by the package and by every RTL file that needs a width or the reset vector. */

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and address width
`define CORE_XLEN 32

// architectural integer registers, x0 included
`define CORE_REG_COUNT 32

// width of a register index
`define CORE_REG_BITS 5

// one instruction word from the cache
`define CORE_INST_BITS 32

// first fetch address after reset
`define CORE_RESET_PC 32'h00000000

`endif

/* source/core.sv */
/* Top level of the in-order RV32I subset core.
   Connects pipeline control, fetch, decode, register file and execute, and
   exposes the instruction cache port and the retire port. */

`include "core_config.svh"

module core (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`CORE_INST_BITS-1:0] icache_data,
  input  logic                       icache_data_valid,
  output logic [`CORE_XLEN-1:0]      icache_addr,
  output core_pkg::retire_t          retire
);

  import core_pkg::*;

  fetch_entry_t          fetch;
  decode_uop_t           uop;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic [`CORE_XLEN-1:0] redirect_pc;
  logic                  hazard;
  logic                  redirect;
  logic                  issue;
  logic                  fetch_hold;
  logic                  decode_hold;
  logic                  decode_flush;
  logic                  issue_bubble;

  pipe_control u_control (
    .clock             (clock),
    .reset             (reset),
    .icache_data_valid (icache_data_valid),
    .hazard            (hazard),
    .redirect          (redirect),
    .fetch_hold        (fetch_hold),
    .decode_hold       (decode_hold),
    .decode_flush      (decode_flush),
    .issue_bubble      (issue_bubble)
  );

  inst_fetch u_fetch (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .fetch_hold        (fetch_hold),
    .decode_hold       (decode_hold),
    .decode_flush      (decode_flush),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .icache_addr       (icache_addr),
    .fetch             (fetch)
  );

  inst_decode u_decode (
    .fetch (fetch),
    .uop   (uop)
  );

  int_regfile u_regfile (
    .clock    (clock),
    .reset    (reset),
    .uop      (uop),
    .issue    (issue),
    .retire   (retire),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .hazard   (hazard)
  );

  int_alu u_alu (
    .clock        (clock),
    .reset        (reset),
    .uop          (uop),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .issue_bubble (issue_bubble),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .issue        (issue),
    .retire       (retire)
  );

endmodule

/* source/core_pkg.sv */
/* Shared types of the core: instruction views, ALU operations and stage records.
   Imported by the RTL modules and by the testbench. */

`include "core_config.svh"

package core_pkg;

  // R-type field layout
  typedef struct packed {
    logic [6:0]                funct7;
    logic [`CORE_REG_BITS-1:0] rs2;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [6:0]                opcode;
  } r_view_t;

  // I-type layout; B and J immediates are rebuilt from this and the R view
  typedef struct packed {
    logic [11:0]               imm;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [2:0]                funct3;
    logic [`CORE_REG_BITS-1:0] rd;
    logic [6:0]                opcode;
  } i_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } inst_word_t;

  // branch kinds share the encoding with the arithmetic ops
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS,
    ALU_BEQ,
    ALU_BNE,
    ALU_JAL
  } alu_op_t;

  // content of the fetch-to-decode register
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    inst_word_t            inst;
  } fetch_entry_t;

  // decoded micro-op, also the payload of the execute register
  typedef struct packed {
    logic                      valid;
    logic [`CORE_XLEN-1:0]     pc;
    alu_op_t                   alu_op;
    logic [`CORE_REG_BITS-1:0] rs1;
    logic [`CORE_REG_BITS-1:0] rs2;
    logic                      rs1_used;
    logic                      rs2_used;
    logic [`CORE_REG_BITS-1:0] rd;
    logic                      rd_valid;
    logic [`CORE_XLEN-1:0]     imm;
    logic                      use_imm;
  } decode_uop_t;

  // one finished instruction; doubles as the register write-back
  typedef struct packed {
    logic                      valid;
    logic [`CORE_XLEN-1:0]     pc;
    logic [`CORE_REG_BITS-1:0] rd;
    logic                      rd_valid;
    logic [`CORE_XLEN-1:0]     rd_data;
  } retire_t;

endpackage

/* source/inst_decode.sv */
/* Combinational decoder for the supported RV32I subset.
   Reads the instruction through both union views, builds the immediates and
   marks sources and destination. Anything unknown leaves as an invalid micro-op. */

`include "core_config.svh"

module inst_decode (
  input  core_pkg::fetch_entry_t fetch,
  output core_pkg::decode_uop_t  uop
);

  import core_pkg::*;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  inst_word_t            inst;
  logic [`CORE_XLEN-1:0] i_imm;
  logic [`CORE_XLEN-1:0] u_imm;
  logic [`CORE_XLEN-1:0] b_imm;
  logic [`CORE_XLEN-1:0] j_imm;
  logic                  legal;
  logic                  writes_rd;

  assign inst = fetch.inst;

  assign i_imm = {{(`CORE_XLEN-12){inst.i_view.imm[11]}}, inst.i_view.imm};
  assign u_imm = {inst.r_view.funct7, inst.r_view.rs2, inst.r_view.rs1,
                  inst.r_view.funct3, 12'b0};
  // imm[12] and imm[10:5] sit in funct7, imm[4:1] and imm[11] in the rd field
  assign b_imm = {{(`CORE_XLEN-12){inst.r_view.funct7[6]}}, inst.r_view.rd[0],
                  inst.r_view.funct7[5:0], inst.r_view.rd[4:1], 1'b0};
  // imm[19:12] is the rs1 and funct3 slot of the I view
  assign j_imm = {{(`CORE_XLEN-20){inst.i_view.imm[11]}}, inst.i_view.rs1,
                  inst.i_view.funct3, inst.i_view.imm[0], inst.i_view.imm[10:1], 1'b0};

  always_comb begin
    uop        = '0;
    uop.pc     = fetch.pc;
    uop.rs1    = inst.r_view.rs1;
    uop.rs2    = inst.r_view.rs2;
    uop.rd     = inst.r_view.rd;
    uop.alu_op = ALU_ADD;
    legal      = 1'b1;
    writes_rd  = 1'b0;
    case (inst.r_view.opcode)
      OP_REG: begin
        uop.rs1_used = 1'b1;
        uop.rs2_used = 1'b1;
        writes_rd    = 1'b1;
        case (inst.r_view.funct3)
          3'b000:  uop.alu_op = inst.r_view.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b111:  uop.alu_op = ALU_AND;
          3'b110:  uop.alu_op = ALU_OR;
          3'b100:  uop.alu_op = ALU_XOR;
          3'b010:  uop.alu_op = ALU_SLT;
          default: legal = 1'b0;
        endcase
        // only SUB may carry the alternate funct7
        if (inst.r_view.funct7 != 7'b0000000 &&
            !(inst.r_view.funct7 == 7'b0100000 && inst.r_view.funct3 == 3'b000)) begin
          legal = 1'b0;
        end
      end
      OP_IMM: begin
        uop.rs1_used = 1'b1;
        uop.use_imm  = 1'b1;
        uop.imm      = i_imm;
        writes_rd    = 1'b1;
        legal        = inst.i_view.funct3 == 3'b000;
      end
      OP_LUI: begin
        uop.alu_op  = ALU_PASS;
        uop.use_imm = 1'b1;
        uop.imm     = u_imm;
        writes_rd   = 1'b1;
      end
      OP_BRANCH: begin
        uop.rs1_used = 1'b1;
        uop.rs2_used = 1'b1;
        uop.imm      = b_imm;
        uop.alu_op   = inst.r_view.funct3[0] ? ALU_BNE : ALU_BEQ;
        legal        = inst.r_view.funct3[2:1] == 2'b00;
      end
      OP_JAL: begin
        uop.alu_op = ALU_JAL;
        uop.imm    = j_imm;
        writes_rd  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // x0 is never written and never marked busy
    uop.rd_valid = writes_rd && uop.rd != '0;
    uop.valid    = fetch.valid && legal;
  end

endmodule

/* source/inst_fetch.sv */
/* Fetch stage: program counter, cache address and the fetch-to-decode register.
   A word is taken on a cache strobe unless fetch is held or a redirect is under way. */

`include "core_config.svh"

module inst_fetch (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`CORE_INST_BITS-1:0] icache_data,
  input  logic                       icache_data_valid,
  input  logic                       fetch_hold,
  input  logic                       decode_hold,
  input  logic                       decode_flush,
  input  logic                       redirect,
  input  logic [`CORE_XLEN-1:0]      redirect_pc,
  output logic [`CORE_XLEN-1:0]      icache_addr,
  output core_pkg::fetch_entry_t     fetch
);

  logic [`CORE_XLEN-1:0] pc;
  logic                  accept;

  // the strobe in a redirect cycle belongs to the wrong path
  assign accept = icache_data_valid & ~fetch_hold & ~redirect;

  // the new target goes out in the same cycle as the redirect
  assign icache_addr = redirect ? redirect_pc : pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `CORE_RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (accept) begin
      pc <= pc + `CORE_XLEN'(4);
    end
  end

  // payload only moves with an accepted word, so a held entry keeps it
  always_ff @(posedge clock) begin
    if (accept) begin
      fetch.pc   <= pc;
      fetch.inst <= icache_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || decode_flush) begin
      fetch.valid <= 1'b0;
    end else if (accept) begin
      fetch.valid <= 1'b1;
    end else if (!decode_hold) begin
      // entry issued this cycle and nothing replaced it
      fetch.valid <= 1'b0;
    end
  end

endmodule

/* source/int_alu.sv */
/* Execute stage: decode-to-execute register, ALU, branch compare and the
   retire register. A taken branch or a JAL redirects fetch from here. */

`include "core_config.svh"

module int_alu (
  input  logic                  clock,
  input  logic                  reset,
  input  core_pkg::decode_uop_t uop,
  input  logic [`CORE_XLEN-1:0] rs1_data,
  input  logic [`CORE_XLEN-1:0] rs2_data,
  input  logic                  issue_bubble,
  output logic                  redirect,
  output logic [`CORE_XLEN-1:0] redirect_pc,
  output logic                  issue,
  output core_pkg::retire_t     retire
);

  import core_pkg::*;

  decode_uop_t           ex_uop;
  logic [`CORE_XLEN-1:0] ex_rs1;
  logic [`CORE_XLEN-1:0] ex_rs2;
  logic [`CORE_XLEN-1:0] operand_b;
  logic [`CORE_XLEN-1:0] result;
  logic                  taken;

  // the instruction in decode is younger than a redirecting one
  assign issue = uop.valid & ~issue_bubble & ~redirect;

  always_ff @(posedge clock) begin
    ex_uop <= uop;
    ex_rs1 <= rs1_data;
    ex_rs2 <= rs2_data;
    if (reset) begin
      ex_uop.valid <= 1'b0;
    end else begin
      ex_uop.valid <= issue;
    end
  end

  assign operand_b = ex_uop.use_imm ? ex_uop.imm : ex_rs2;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (ex_uop.alu_op)
      ALU_ADD:  result = ex_rs1 + operand_b;
      ALU_SUB:  result = ex_rs1 - operand_b;
      ALU_AND:  result = ex_rs1 & operand_b;
      ALU_OR:   result = ex_rs1 | operand_b;
      ALU_XOR:  result = ex_rs1 ^ operand_b;
      ALU_SLT:  result[0] = $signed(ex_rs1) < $signed(operand_b);
      ALU_PASS: result = ex_uop.imm;
      ALU_BEQ:  taken = ex_rs1 == ex_rs2;
      ALU_BNE:  taken = ex_rs1 != ex_rs2;
      ALU_JAL: begin
        // link value
        result = ex_uop.pc + `CORE_XLEN'(4);
        taken  = 1'b1;
      end
      default:  result = '0;
    endcase
  end

  assign redirect    = ex_uop.valid & taken;
  assign redirect_pc = ex_uop.pc + ex_uop.imm;

  always_ff @(posedge clock) begin
    retire.pc       <= ex_uop.pc;
    retire.rd       <= ex_uop.rd;
    retire.rd_valid <= ex_uop.rd_valid;
    retire.rd_data  <= result;
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= ex_uop.valid;
    end
  end

endmodule

/* source/int_regfile.sv */
/* Integer register file with two read ports, one write port and a busy scoreboard.
   Raises hazard while a used source waits for its producer. Reads see a
   write from the retire port in the same cycle. */

`include "core_config.svh"

module int_regfile (
  input  logic                  clock,
  input  logic                  reset,
  input  core_pkg::decode_uop_t uop,
  input  logic                  issue,
  input  core_pkg::retire_t     retire,
  output logic [`CORE_XLEN-1:0] rs1_data,
  output logic [`CORE_XLEN-1:0] rs2_data,
  output logic                  hazard
);

  // x0 has no storage
  logic [`CORE_XLEN-1:0]      regs [1:`CORE_REG_COUNT-1];
  logic [`CORE_REG_COUNT-1:0] busy;
  logic                       write_en;

  assign write_en = retire.valid & retire.rd_valid;

  function automatic logic [`CORE_XLEN-1:0] read_reg(
    input logic [`CORE_REG_BITS-1:0] idx
  );
    logic [`CORE_XLEN-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (write_en && retire.rd == idx) begin
      // write-before-read bypass
      value = retire.rd_data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_reg(uop.rs1);
    rs2_data = read_reg(uop.rs2);
  end

  // architectural state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[retire.rd] <= retire.rd_data;
    end
  end

  // Execute is a single stage that always drains, so every busy bit clears on
  // the edge that loads its producer into the retire register.
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= '0;
      if (issue && uop.rd_valid) begin
        busy[uop.rd] <= 1'b1;
      end
    end
  end

  assign hazard = uop.valid & ((uop.rs1_used & busy[uop.rs1]) |
                               (uop.rs2_used & busy[uop.rs2]));

endmodule

/* source/pipe_control.sv */
/* Central hold and flush control of the pipeline.
   Holds fetch and decode under a scoreboard hazard, flushes them on a redirect
   and drops the first cache strobe seen after a redirect. */

module pipe_control (
  input  logic clock,
  input  logic reset,
  input  logic icache_data_valid,
  input  logic hazard,
  input  logic redirect,
  output logic fetch_hold,
  output logic decode_hold,
  output logic decode_flush,
  output logic issue_bubble
);

  // high for the one cycle that follows a redirect
  logic discard;
  logic stale_strobe;

  always_ff @(posedge clock) begin
    if (reset) begin
      discard <= 1'b0;
    end else begin
      discard <= redirect;
    end
  end

  // a strobe right after a redirect may still answer the old address
  assign stale_strobe = discard & icache_data_valid;

  // the PC and the cache strobe wait while decode is stuck
  assign fetch_hold = hazard | stale_strobe;

  // a flush wins over a hold since the held instruction is younger than the branch
  assign decode_hold = hazard & ~redirect;

  assign decode_flush = redirect;

  // nothing leaves decode while a source is busy
  assign issue_bubble = hazard;

endmodule

/* verilog.f */
+incdir+include
source/core_pkg.sv
source/pipe_control.sv
source/inst_fetch.sv
source/inst_decode.sv
source/int_regfile.sv
source/int_alu.sv
source/core.sv
dv/core_props.sv
dv/core_tb.sv
